/* hw/link_pkg.sv */
package link_pkg;

  // one spi data byte, also one host memory byte
  typedef logic [7:0] byte_t;

  // command code, first byte of every command
  typedef logic [7:0] opcode_t;

  // kept command set
  localparam opcode_t OP_GET_COOKIE  = 8'd0;   // reply af
  localparam opcode_t OP_BRAM_POKE   = 8'd1;   // addr lo, addr hi, data
  localparam opcode_t OP_BRAM_PEEK   = 8'd2;   // addr lo, addr hi, reply data
  localparam opcode_t OP_GET_VERSION = 8'd15;  // reply {major, minor}

  // longest parameter list, poke
  localparam int MAX_PARAMS = 3;

  // parser states
  typedef enum logic [0:0] {
    PARSE_IDLE,    // next byte is an opcode
    PARSE_PARAMS   // collecting parameter bytes
  } parse_state_t;

  // fixed answer to get_cookie, lets the host find the board
  localparam byte_t COOKIE = 8'haf;

  // version byte, major in the top 3 bits
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // a command travels in one cs frame
  // its reply is shifted out in the frame after it
  // frames carry whole bytes, msb first

endpackage

/* hw/host_ram.sv */
`timescale 1ns/1ps

module host_ram #(
  parameter int ADDR_W = 15
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  link_pkg::byte_t   wdata,
  output link_pkg::byte_t   rdata
);

  // 2**ADDR_W bytes, contents undefined after power up
  link_pkg::byte_t mem [2**ADDR_W];

  // single port, read-first
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old data on a write cycle
    end
  end

endmodule

/* hw/spi_slave_link.sv */
`timescale 1ns/1ps

module spi_slave_link (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sck,
  input  logic            cs_n,
  input  logic            mosi,
  input  link_pkg::byte_t reply_byte,
  input  logic            reply_valid,
  output logic            miso,
  output link_pkg::byte_t rx_byte,
  output logic            rx_valid,
  output logic            frame_start,
  output logic            frame_abort
);

  logic [2:0] sck_r;     // sck synchroniser, [2] is the history bit
  logic [2:0] cs_r;      // cs_n synchroniser
  logic [1:0] mosi_r;    // lines up with sck_r[1]
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic       cs_fall;
  logic       cs_rise;
  logic [2:0] bit_cnt;   // bits of the current byte
  link_pkg::byte_t rx_shift;
  link_pkg::byte_t tx_shift;
  link_pkg::byte_t pending_byte;
  logic            pending_valid;

  // pins are async to clk
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_r  <= 3'b000;  // idle low, mode 0
      cs_r   <= 3'b111;  // deselected
      mosi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];
  assign cs_fall   = (cs_r[2:1] == 2'b10);
  assign cs_rise   = (cs_r[2:1] == 2'b01);

  assign frame_start = cs_fall;
  assign frame_abort = cs_rise && (bit_cnt != 3'd0);  // partial byte dropped

  // receive side, mosi sampled on sck rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active) begin
        bit_cnt <= 3'd0;  // next frame starts on a byte boundary
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_r[1]};  // msb first
    end
  end

  assign rx_byte = rx_shift;  // complete while rx_valid is high

  // reply waits here until the next frame opens
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_valid <= 1'b0;
    end else if (reply_valid) begin
      pending_valid <= 1'b1;  // newer reply replaces the old one
    end else if (frame_start) begin
      pending_valid <= 1'b0;  // consumed by this frame
    end
  end

  always_ff @(posedge clk) begin
    if (reply_valid) begin
      pending_byte <= reply_byte;
    end
  end

  // transmit side, bit 7 is on the pin before the first sck rise
  always_ff @(posedge clk) begin
    if (frame_start) begin
      tx_shift <= pending_valid ? pending_byte : 8'h00;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};  // zeros after the first byte
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'b0;  // low when deselected

endmodule

/* hw/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser (
  input  logic              clk,
  input  logic              rst_n,
  input  link_pkg::byte_t   rx_byte,
  input  logic              rx_valid,
  input  logic              frame_start,
  input  logic              frame_abort,
  output logic              cmd_valid,
  output link_pkg::opcode_t cmd_op,
  output link_pkg::byte_t   cmd_p0,
  output link_pkg::byte_t   cmd_p1,
  output link_pkg::byte_t   cmd_p2
);

  // wide enough to count up to MAX_PARAMS
  localparam int CNT_W = $clog2(link_pkg::MAX_PARAMS + 1);

  link_pkg::parse_state_t state;
  logic [CNT_W-1:0]       param_cnt;  // parameters this opcode needs
  logic [CNT_W-1:0]       param_idx;  // next slot to fill
  logic                   last_param;

  assign last_param = (param_idx == param_cnt - CNT_W'(1));

  // control path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= link_pkg::PARSE_IDLE;
      param_cnt <= '0;
      param_idx <= '0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;  // single cycle pulse
      if (frame_start || frame_abort) begin
        state <= link_pkg::PARSE_IDLE;  // cs edge drops a half-done command
      end else if (rx_valid) begin
        case (state)
          link_pkg::PARSE_IDLE: begin
            param_idx <= '0;
            case (rx_byte)
              link_pkg::OP_GET_COOKIE,
              link_pkg::OP_GET_VERSION: begin
                cmd_valid <= 1'b1;  // no parameters, issue now
              end
              link_pkg::OP_BRAM_POKE: begin
                param_cnt <= CNT_W'(link_pkg::MAX_PARAMS);
                state     <= link_pkg::PARSE_PARAMS;
              end
              link_pkg::OP_BRAM_PEEK: begin
                param_cnt <= CNT_W'(2);  // address only
                state     <= link_pkg::PARSE_PARAMS;
              end
              default: ;  // unknown opcode, ignored
            endcase
          end
          link_pkg::PARSE_PARAMS: begin
            param_idx <= param_idx + CNT_W'(1);
            if (last_param) begin
              cmd_valid <= 1'b1;
              state     <= link_pkg::PARSE_IDLE;
            end
          end
          default: state <= link_pkg::PARSE_IDLE;
        endcase
      end
    end
  end

  // opcode and parameter slots, payload only
  always_ff @(posedge clk) begin
    if (rx_valid && !frame_start && !frame_abort) begin
      if (state == link_pkg::PARSE_IDLE) begin
        cmd_op <= rx_byte;
      end else begin
        case (param_idx)
          CNT_W'(0): cmd_p0 <= rx_byte;  // address low
          CNT_W'(1): cmd_p1 <= rx_byte;  // address high
          default:   cmd_p2 <= rx_byte;  // poke data
        endcase
      end
    end
  end

endmodule

/* hw/cmd_exec.sv */
`timescale 1ns/1ps

module cmd_exec #(
  parameter int ADDR_W = 15
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  link_pkg::opcode_t cmd_op,
  input  link_pkg::byte_t   cmd_p0,
  input  link_pkg::byte_t   cmd_p1,
  input  link_pkg::byte_t   cmd_p2,
  input  link_pkg::byte_t   ram_rdata,
  output logic              ram_en,
  output logic              ram_we,
  output logic [ADDR_W-1:0] ram_addr,
  output link_pkg::byte_t   ram_wdata,
  output link_pkg::byte_t   reply_byte,
  output logic              reply_valid
);

  logic [15:0] full_addr;  // {hi, lo} as sent by the host
  logic        is_poke;
  logic        is_peek;
  logic        rd_pending; // peek data arrives next cycle

  assign full_addr = {cmd_p1, cmd_p0};
  assign is_poke   = (cmd_op == link_pkg::OP_BRAM_POKE);
  assign is_peek   = (cmd_op == link_pkg::OP_BRAM_PEEK);

  // memory access issued in the cmd_valid cycle
  assign ram_en    = cmd_valid && (is_poke || is_peek);
  assign ram_we    = cmd_valid && is_poke;
  assign ram_addr  = full_addr[ADDR_W-1:0];  // upper bits ignored
  assign ram_wdata = cmd_p2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending  <= 1'b0;
      reply_valid <= 1'b0;
    end else begin
      rd_pending  <= cmd_valid && is_peek;
      reply_valid <= rd_pending ||
                     (cmd_valid && (cmd_op == link_pkg::OP_GET_COOKIE)) ||
                     (cmd_valid && (cmd_op == link_pkg::OP_GET_VERSION));
    end
  end

  // reply data, read return has priority
  always_ff @(posedge clk) begin
    if (rd_pending) begin
      reply_byte <= ram_rdata;
    end else if (cmd_valid) begin
      case (cmd_op)
        link_pkg::OP_GET_COOKIE:  reply_byte <= link_pkg::COOKIE;
        link_pkg::OP_GET_VERSION: begin
          reply_byte <= {link_pkg::VERSION_MAJOR, link_pkg::VERSION_MINOR};
        end
        default: ;  // poke gives no reply
      endcase
    end
  end

endmodule

/* hw/link_top.sv */
`timescale 1ns/1ps

module link_top #(
  parameter int ADDR_W = 15  // host memory address width, 8 to 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  link_pkg::byte_t   rx_byte;
  logic              rx_valid;
  logic              frame_start;
  logic              frame_abort;
  logic              cmd_valid;
  link_pkg::opcode_t cmd_op;
  link_pkg::byte_t   cmd_p0;
  link_pkg::byte_t   cmd_p1;
  link_pkg::byte_t   cmd_p2;
  logic              ram_en;
  logic              ram_we;
  logic [ADDR_W-1:0] ram_addr;
  link_pkg::byte_t   ram_wdata;
  link_pkg::byte_t   ram_rdata;
  link_pkg::byte_t   reply_byte;
  logic              reply_valid;

  // pins in, bytes out, replies back in
  spi_slave_link u_spi (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .reply_byte  (reply_byte),
    .reply_valid (reply_valid),
    .miso        (miso),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort)
  );

  cmd_parser u_parser (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_p0      (cmd_p0),
    .cmd_p1      (cmd_p1),
    .cmd_p2      (cmd_p2)
  );

  cmd_exec #(.ADDR_W(ADDR_W)) u_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_p0      (cmd_p0),
    .cmd_p1      (cmd_p1),
    .cmd_p2      (cmd_p2),
    .ram_rdata   (ram_rdata),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .reply_byte  (reply_byte),
    .reply_valid (reply_valid)
  );

  // inferred block ram on clk
  host_ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

/* bench/link_properties.sv */
`timescale 1ns/1ps

module link_properties (
  input logic clk,
  input logic rst_n,
  input logic sck,          // raw pin, before the synchroniser
  input logic cs_n,         // raw pin, before the synchroniser
  input logic miso,
  input logic rx_valid,
  input logic reply_valid
);

  int assert_fails = 0;  // read by the testbench top at the end

  // pin must not float high between frames
  // cs seen through two sync flops
  miso_low_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) $past(cs_n, 2) |-> !miso
  ) else begin
    assert_fails++;
    $error("miso is high while cs is inactive");
  end

  // one pulse per sck rise, 3 clk behind the pin, so never two cycles long
  rx_valid_after_sck_rise: assert property (
    @(posedge clk) disable iff (!rst_n) rx_valid |-> $past(sck, 3) && !$past(sck, 4)
  ) else begin
    assert_fails++;
    $error("rx_valid not a single pulse 3 clk after an sck rise");
  end

  // replies trail the received byte by at least two clk
  reply_not_with_rx: assert property (
    @(posedge clk) disable iff (!rst_n) !(reply_valid && rx_valid)
  ) else begin
    assert_fails++;
    $error("reply_valid and rx_valid high in the same cycle");
  end

endmodule

bind spi_slave_link link_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .sck         (sck),
  .cs_n        (cs_n),
  .miso        (miso),
  .rx_valid    (rx_valid),
  .reply_valid (reply_valid)
);

/* bench/tb_link_checker.sv */
`timescale 1ns/1ps

module tb_link_checker #(
  parameter int ADDR_W = 15
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic mosi,
  input  logic miso,
  output int   errors,
  output int   checks
);

  logic       sck_q;
  logic       cs_q;
  logic [7:0] mosi_sr;
  logic [7:0] miso_sr;
  int         bit_cnt;      // bits seen in the open frame
  int         frame_no;
  logic [7:0] exp_reply;    // first miso byte expected in this frame
  logic       exp_known;
  logic [7:0] new_reply;    // reply made by commands of this frame
  logic       new_known;
  logic       in_params;
  logic [7:0] op;
  logic [7:0] prm [3];
  int         prm_cnt;
  logic [7:0] shadow [int]; // host memory model, written bytes only

  // host sends {hi, lo}, memory sees the low ADDR_W bits
  function automatic int mem_addr(input logic [7:0] lo, input logic [7:0] hi);
    return int'({hi, lo}) & ((1 << ADDR_W) - 1);
  endfunction

  // command rules applied to one received byte
  task automatic take_byte(input logic [7:0] b);
    int a;
    if (!in_params) begin
      op      = b;
      prm_cnt = 0;
      case (b)
        8'h00: new_reply = 8'haf;   // cookie
        8'h0f: new_reply = 8'h03;   // version 0.3
        8'h01, 8'h02: in_params = 1'b1;
        default: ;                  // unknown, dropped
      endcase
    end else begin
      prm[prm_cnt] = b;
      prm_cnt++;
      if (op == 8'h01 && prm_cnt == 3) begin
        shadow[mem_addr(prm[0], prm[1])] = prm[2];
        in_params = 1'b0;
      end else if (op == 8'h02 && prm_cnt == 2) begin
        a         = mem_addr(prm[0], prm[1]);
        new_known = shadow.exists(a);
        new_reply = new_known ? shadow[a] : 8'h00;
        in_params = 1'b0;
      end
    end
  endtask

  task automatic check_miso(input logic [7:0] got, input logic [7:0] want, input logic known);
    if (known) begin
      checks++;
      if (got !== want) begin
        errors++;
        $display("FAIL %0t: frame %0d byte %0d miso %02h, expected %02h",
                 $time, frame_no, bit_cnt / 8 - 1, got, want);
      end
    end
  endtask

  // pins move on the falling clk edge, so the rising edge sees them settled
  always @(posedge clk) begin
    if (!rst_n) begin
      sck_q     = 1'b0;
      cs_q      = 1'b1;
      bit_cnt   = 0;
      frame_no  = 0;
      exp_reply = 8'h00;  // nothing pending after reset
      exp_known = 1'b1;
      in_params = 1'b0;
      errors    = 0;
      checks    = 0;
    end else begin
      if (cs_q && !cs_n) begin   // frame opens, parser back to idle
        bit_cnt   = 0;
        in_params = 1'b0;
        new_reply = 8'h00;
        new_known = 1'b1;
      end
      if (!cs_n && !sck_q && sck) begin
        mosi_sr = {mosi_sr[6:0], mosi};
        miso_sr = {miso_sr[6:0], miso};
        bit_cnt++;
        if (bit_cnt % 8 == 0) begin
          if (bit_cnt == 8) begin
            check_miso(miso_sr, exp_reply, exp_known);
          end else begin
            check_miso(miso_sr, 8'h00, 1'b1);  // zeros after the reply
          end
          take_byte(mosi_sr);
        end
      end
      if (!cs_q && cs_n) begin   // frame closes, partial byte dropped
        exp_reply = new_reply;
        exp_known = new_known;
        in_params = 1'b0;
        frame_no++;
      end
      sck_q = sck;
      cs_q  = cs_n;
    end
  end

endmodule

/* bench/tb_link_top.sv */
`timescale 1ns/1ps

module tb_link_top;

  localparam int ADDR_W    = 15;
  localparam int CLK_NS    = 40;
  localparam int HALF_CLK  = 4;   // sck half period in clk
  localparam int GAP_CLK   = 10;  // cs high between frames
  localparam int N_CMDS    = 200;
  localparam int FRAME_CLK = 32 * 2 * HALF_CLK + HALF_CLK + GAP_CLK;  // 4 byte frame
  localparam longint WATCHDOG_NS =
    longint'(N_CMDS) * 5 * FRAME_CLK * CLK_NS + 200_000;

  logic        clk;
  logic        rst_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  int          errors;
  int          checks;
  logic [31:0] lfsr;
  logic [7:0]  pool_lo [8];  // small address pool so peeks hit pokes
  logic [7:0]  pool_hi [8];
  logic        written [8];
  int          n;

  link_top #(.ADDR_W(ADDR_W)) u_link_top (
    .clk   (clk),
    .rst_n (rst_n),
    .sck   (sck),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  tb_link_checker #(.ADDR_W(ADDR_W)) u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .sck    (sck),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .miso   (miso),
    .errors (errors),
    .checks (checks)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < nbits; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // mode 0 master, bytes packed msb first from bit 31
  task automatic send_frame(input logic [31:0] data, input int nbytes, input int abort_bits);
    int total;
    int b;
    total = (abort_bits > 0) ? abort_bits : nbytes * 8;
    cs_n  = 1'b0;
    for (b = 0; b < total; b++) begin
      mosi = data[31 - b];
      repeat (HALF_CLK) @(negedge clk);
      sck = 1'b1;                        // slave samples here
      repeat (HALF_CLK) @(negedge clk);
      sck = 1'b0;                        // slave shifts miso here
    end
    repeat (HALF_CLK) @(negedge clk);
    cs_n = 1'b1;                         // mid-byte when aborting
    mosi = 1'b0;
    repeat (GAP_CLK) @(negedge clk);
  endtask

  // kind 0 cookie, 1 version, 2-3 poke, 4-5 peek, 6 unknown, 7 aborted poke
  task automatic issue_cmd(input int kind);
    logic [31:0] frame;
    logic [7:0]  op;
    int          idx;
    int          nbytes;
    int          abort_bits;
    int          k;
    frame      = '0;
    nbytes     = 1;
    abort_bits = 0;
    k          = kind;
    idx        = int'(rand_bits(3));
    if ((k == 4 || k == 5) && !written[idx]) k = 2;  // peek only written bytes
    case (k)
      0: frame[31:24] = 8'h00;
      1: frame[31:24] = 8'h0f;
      2, 3: begin
        frame        = {8'h01, pool_lo[idx], pool_hi[idx], 8'(rand_bits(8))};
        nbytes       = 4;
        written[idx] = 1'b1;
      end
      4, 5: begin
        frame  = {8'h02, pool_lo[idx], pool_hi[idx], 8'h00};
        nbytes = 3;
      end
      6: begin
        op = 8'(rand_bits(8));
        if (op == 8'h00 || op == 8'h01 || op == 8'h02 || op == 8'h0f) op = op ^ 8'h40;
        frame[31:24] = op;
      end
      default: begin
        frame      = {8'h01, pool_lo[idx], pool_hi[idx], 8'(rand_bits(8))};
        nbytes     = 4;
        abort_bits = int'(rand_bits(5));
        if (abort_bits % 8 == 0) abort_bits = abort_bits + 3;  // never whole bytes
      end
    endcase
    send_frame(frame, nbytes, abort_bits);
    send_frame(32'h0, 1, 0);  // dummy 00 collects the reply
  endtask

  initial begin
    lfsr  = 32'h61d5_d3c0;
    rst_n = 1'b0;
    sck   = 1'b0;
    cs_n  = 1'b1;
    mosi  = 1'b0;
    for (n = 0; n < 8; n++) begin
      pool_lo[n] = 8'(rand_bits(8));
      pool_hi[n] = 8'(rand_bits(8));  // top bit is outside the 15 bit space
      written[n] = 1'b0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    issue_cmd(0);
    issue_cmd(1);
    issue_cmd(2);
    issue_cmd(4);
    for (n = 0; n < N_CMDS; n++) begin
      issue_cmd(int'(rand_bits(3)));
    end
    repeat (20) @(negedge clk);
    $display("replies checked %0d, value errors %0d, assertion failures %0d",
             checks, errors, u_link_top.u_spi.u_props.assert_fails);
    if (errors == 0 && checks > 0 && u_link_top.u_spi.u_props.assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // bound by the slowest possible command sequence
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* sim.f */
hw/link_pkg.sv
hw/host_ram.sv
hw/spi_slave_link.sv
hw/cmd_parser.sv
hw/cmd_exec.sv
hw/link_top.sv
bench/link_properties.sv
bench/tb_link_checker.sv
bench/tb_link_top.sv

/* Makefile */
# Verilator flow for the SPI command link

VERILATOR  ?= verilator
TOP        ?= tb_link_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= *** PASSED ***
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides, the binary status is not trusted alone
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
